//--- Makefile
# Verilator build and run for the SIMD ALU testbench

VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/alu_model.svh
// SIMD ALU reference model
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// element width for a vector mode
function automatic int element_width(vec_mode_e mode);
  case (mode)
    VEC_MODE8:  return 8;
    VEC_MODE16: return 16;
    default:    return 32;
  endcase
endfunction

// outcome for one element, operands already in signed or unsigned form
function automatic logic element_outcome(alu_opcode_e op, longint a, longint b);
  case (op)
    NE:                     return a != b;
    GTS, GTU:               return a > b;
    GES, GEU:               return a >= b;
    LTS, LTU, SLTS, SLTU:   return a < b;
    LES, LEU, SLETS, SLETU: return a <= b;
    // non-compare ops report equality
    default:                return a == b;
  endcase
endfunction

// expected result, element by element from the bottom up
function automatic alu_res_t expected_result(alu_req_t r);
  alu_res_t res;
  int       w;
  longint   lim;
  longint   ua;
  longint   ub;
  longint   va;
  longint   vb;
  longint   elem;
  logic     sgn;
  logic     outc;
  w   = element_width(r.vector_mode);
  lim = longint'(1) << w;
  sgn = r.operator inside {GTS, GES, LTS, LES, SLTS, SLETS, MIN, MAX, ABS};
  res = '0;
  for (int e = 0; e < 32 / w; e++) begin
    ua   = longint'(r.operand_a >> (e * w)) & (lim - 1);
    ub   = longint'(r.operand_b >> (e * w)) & (lim - 1);
    // two's complement view of the element
    va   = (sgn && ua >= lim / 2) ? ua - lim : ua;
    vb   = (sgn && ub >= lim / 2) ? ub - lim : ub;
    outc = element_outcome(r.operator, va, vb);
    case (r.operator)
      ADD:       elem = ua + ub;
      SUB:       elem = ua - ub;
      ABS:       elem = (va > vb) ? ua : -ua;
      AND:       elem = ua & ub;
      OR:        elem = ua | ub;
      XOR:       elem = ua ^ ub;
      MIN, MINU: elem = (va < vb) ? ua : ub;
      MAX, MAXU: elem = (va > vb) ? ua : ub;
      SLTS, SLTU, SLETS, SLETU: elem = 0;
      // lane masks
      default:   elem = outc ? lim - 1 : 0;
    endcase
    // wraps modulo the element width
    res.result = res.result | word_t'((elem & (lim - 1)) << (e * w));
    // last pass is the top element
    res.comparison_result = outc;
  end
  if (r.operator inside {SLTS, SLTU, SLETS, SLETU}) begin
    res.result = {31'b0, res.comparison_result};
  end
  return res;
endfunction

`endif

//--- tb/alu_tb.sv
// SIMD ALU testbench
`timescale 1ns/1ps
`default_nettype none

module alu_tb
  import alu_op_pkg::*, alu_data_pkg::*;
();

  localparam logic [31:0] SEED        = 32'hfceb2763;
  // cycles without any handshake before a test gives up
  localparam int          TIMEOUT_CYC = 100;

  logic     clk;
  logic     rst_n;
  logic     enable;
  alu_req_t req;
  logic     ready;
  logic     result_valid;
  alu_res_t result;
  logic     ex_ready;

  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          cyc;
  logic        aborted;
  // expected results and their acceptance cycles, in request order
  alu_res_t    exp_q[$];
  int          acc_q[$];

  `include "alu_model.svh"

  alu_top alu_top_i (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .enable_i      (enable),
    .req_i         (req),
    .ready_o       (ready),
    .result_valid_o(result_valid),
    .result_o      (result),
    .ex_ready_i    (ex_ready)
  );

  always #4 clk = ~clk;

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // opcode drawn from a run of consecutive codes
  function automatic alu_opcode_e pick_op(alu_opcode_e first, int count);
    logic [4:0] code;
    code = first + 5'(next_rand() % 32'(count));
    return alu_opcode_e'(code);
  endfunction

  // kind 0 arith, 1 logic, 2 compare, 3 min/max, 4 any
  function automatic alu_req_t random_request(int kind);
    alu_req_t    r;
    logic [31:0] rm;
    r.operand_a = next_rand();
    r.operand_b = next_rand();
    rm          = next_rand();
    case (rm % 32'd3)
      32'd0:   r.vector_mode = VEC_MODE32;
      32'd1:   r.vector_mode = VEC_MODE16;
      default: r.vector_mode = VEC_MODE8;
    endcase
    case (kind)
      0:       r.operator = pick_op(ADD, 3);
      1:       r.operator = pick_op(AND, 3);
      2:       r.operator = pick_op(EQ, 14);
      3:       r.operator = pick_op(MIN, 4);
      default: r.operator = pick_op(ADD, 24);
    endcase
    // copy bytes of a into b so equal lanes show up often
    if (kind >= 2) begin
      for (int i = 0; i < 4; i++) begin
        if (rm[8+i]) begin
          r.operand_b[8*i +: 8] = r.operand_a[8*i +: 8];
        end
      end
    end
    if (r.operator == ABS) begin
      r.operand_b = '0;
    end
    return r;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic check_value(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] got);
    checks++;
    assert (got == exp_v) else begin
      $display("[ERROR] %0t %s: expected %h got %h", $time, sig, exp_v, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%0t %s", $time, msg);
      errors++;
    end
  endtask

  task automatic reset_test();
    int e0;
    int c0;
    e0 = errors;
    c0 = checks;
    @(negedge clk);
    #1;
    check_value("result_valid_o", 32'd0, {31'b0, result_valid});
    check_value("ready_o", 32'd1, {31'b0, ready});
    $display("test 1 reset: %0d checks, %0d errors", checks - c0, errors - e0);
  endtask

  ////////////////////
  // test runner
  ////////////////////

  // drive on the falling edge, sample 1 ns later when everything has settled
  task automatic run_test(input int num, input string name, input int kind,
                          input int count, input logic stall, input logic check_lat);
    int          sent;
    int          idle;
    int          e0;
    int          c0;
    int          acc;
    logic        pending;
    logic        held_valid;
    logic        moved;
    logic [31:0] rnd;
    alu_res_t    exp;
    alu_res_t    held;
    sent       = 0;
    idle       = 0;
    pending    = 1'b0;
    held_valid = 1'b0;
    e0         = errors;
    c0         = checks;
    while ((sent < count || exp_q.size() != 0) && !aborted) begin
      @(negedge clk);
      rnd = next_rand();
      // a new request only once the last one was taken
      if (!pending && sent < count) begin
        req     = random_request(kind);
        pending = 1'b1;
      end
      enable   = pending & (~stall | rnd[3]);
      ex_ready = stall ? rnd[9] : 1'b1;
      #1;
      moved = 1'b0;
      // result must not move while stalled
      if (held_valid) begin
        check_value("result_o.result", held.result, result.result);
        check_value("result_o.comparison_result", {31'b0, held.comparison_result},
                    {31'b0, result.comparison_result});
        held_valid = 1'b0;
      end
      if (result_valid && ex_ready) begin
        moved = 1'b1;
        check_true(exp_q.size() != 0, "result appeared with no request outstanding");
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          acc = acc_q.pop_front();
          check_value("result_o.result", exp.result, result.result);
          check_value("result_o.comparison_result", {31'b0, exp.comparison_result},
                      {31'b0, result.comparison_result});
          if (check_lat) begin
            check_true(cyc - acc == 2,
                       $sformatf("result took %0d cycles instead of 2", cyc - acc));
          end
        end
      end else if (result_valid) begin
        held       = result;
        held_valid = 1'b1;
      end
      if (enable && ready) begin
        moved = 1'b1;
        exp_q.push_back(expected_result(req));
        acc_q.push_back(cyc);
        sent++;
        pending = 1'b0;
      end
      if (moved) begin
        idle = 0;
      end else begin
        idle++;
      end
      cyc++;
      if (idle > TIMEOUT_CYC) begin
        $display("%0t test %0d stopped, no handshake for %0d cycles", $time, num, idle);
        errors++;
        aborted = 1'b1;
      end
    end
    enable = 1'b0;
    $display("test %0d %s: %0d checks, %0d errors", num, name, checks - c0, errors - e0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    enable    = 1'b0;
    req       = '0;
    ex_ready  = 1'b1;
    lcg_state = SEED;
    errors    = 0;
    checks    = 0;
    cyc       = 0;
    aborted   = 1'b0;
    // two rising edges in reset
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    reset_test();
    run_test(2, "add/sub/abs", 0, 300, 1'b0, 1'b0);
    if (!aborted) run_test(3, "logic", 1, 200, 1'b0, 1'b1);
    if (!aborted) run_test(4, "compare", 2, 400, 1'b0, 1'b0);
    if (!aborted) run_test(5, "min/max", 3, 300, 1'b0, 1'b0);
    if (!aborted) run_test(6, "backpressure", 4, 500, 1'b1, 1'b0);
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tb
verilog/alu_op_pkg.sv
verilog/alu_data_pkg.sv
verilog/alu_stage_reg.sv
verilog/alu_lane_adder.sv
verilog/alu_lane_compare.sv
verilog/alu_result_mux.sv
verilog/alu_top.sv
tb/alu_tb.sv

//--- verilog/alu_data_pkg.sv
// SIMD ALU data shapes
`default_nettype none

package alu_data_pkg;

  import alu_op_pkg::*;

  ////////////////////
  // widths
  ////////////////////

  // full operand word
  localparam int WORD_W    = 32;
  // smallest lane, one byte
  localparam int LANE_W    = 8;
  // byte lanes in a word
  localparam int NUM_LANES = WORD_W / LANE_W;

  typedef logic [WORD_W-1:0]    word_t;
  // one bit per byte lane, bit 3 is the top byte
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  ////////////////////
  // request and result
  ////////////////////

  // one operation as it enters the pipeline, 71 bits
  typedef struct packed {
    alu_opcode_e operator;
    vec_mode_e   vector_mode;
    word_t       operand_a;
    word_t       operand_b;
  } alu_req_t;

  // word result plus the top-lane compare outcome, 33 bits
  typedef struct packed {
    word_t result;
    logic  comparison_result;
  } alu_res_t;

  // comparator output
  // flags of a 16 or 32 bit element are copied to all its bytes
  typedef struct packed {
    lane_mask_t is_equal;
    lane_mask_t is_greater;
  } cmp_flags_t;

endpackage

`default_nettype wire

//--- verilog/alu_lane_adder.sv
// Partitioned SIMD adder
`timescale 1ns/1ps
`default_nettype none

module alu_lane_adder
  import alu_op_pkg::*, alu_data_pkg::*;
(
  input  alu_req_t req_i,
  output word_t    sum_o
);

  // one guard bit below every byte lane
  localparam int EXT_W = WORD_W + NUM_LANES;

  logic                 is_abs;
  logic                 carry_in;
  word_t                op_a;
  word_t                op_b;
  lane_mask_t           lane_start;
  logic [EXT_W-1:0]     in_a;
  logic [EXT_W-1:0]     in_b;
  logic [EXT_W-1:0]     sum_ext;

  ////////////////////
  // operand prep
  ////////////////////

  assign is_abs = (req_i.operator == ABS);

  // sub and abs add one at the bottom of each element
  assign carry_in = op_negates_b(req_i.operator) | is_abs;

  // abs forms 0 - a as ~a + 0 + 1
  assign op_a = is_abs ? ~req_i.operand_a : req_i.operand_a;

  always_comb begin
    op_b = req_i.operand_b;
    if (is_abs) begin
      op_b = '0;
    end else if (op_negates_b(req_i.operator)) begin
      op_b = ~req_i.operand_b;
    end
  end

  // byte lanes where a new element begins
  always_comb begin
    case (req_i.vector_mode)
      VEC_MODE8:  lane_start = 4'b1111;
      VEC_MODE16: lane_start = 4'b0101;
      default:    lane_start = 4'b0001;
    endcase
  end

  ////////////////////
  // guarded add
  ////////////////////

  // guard a=1 b=0 lets a carry ripple through inside an element
  // guard a=b=0 kills it, a=b=1 forces the +1 of a negation
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    assign in_a[(LANE_W+1)*i]              = lane_start[i] ? carry_in : 1'b1;
    assign in_b[(LANE_W+1)*i]              = lane_start[i] & carry_in;
    assign in_a[(LANE_W+1)*i+1 +: LANE_W]  = op_a[LANE_W*i +: LANE_W];
    assign in_b[(LANE_W+1)*i+1 +: LANE_W]  = op_b[LANE_W*i +: LANE_W];
    // drop the guard positions again
    assign sum_o[LANE_W*i +: LANE_W]       = sum_ext[(LANE_W+1)*i+1 +: LANE_W];
  end

  // one carry chain for the whole word, top carry out is discarded
  assign sum_ext = in_a + in_b;

endmodule

`default_nettype wire

//--- verilog/alu_lane_compare.sv
// SIMD lane comparator
`timescale 1ns/1ps
`default_nettype none

module alu_lane_compare
  import alu_op_pkg::*, alu_data_pkg::*;
(
  input  alu_req_t   req_i,
  output cmp_flags_t flags_o
);

  lane_mask_t cmp_signed;
  lane_mask_t eq_byte;
  lane_mask_t gt_byte;
  logic       eq_lo16;
  logic       eq_hi16;
  logic       gt_lo16;
  logic       gt_hi16;
  logic       eq_32;
  logic       gt_32;

  ////////////////////
  // byte compare
  ////////////////////

  // only the sign byte of an element is compared signed
  // lower bytes of the same element stay unsigned
  always_comb begin
    cmp_signed = '0;
    if (op_is_signed(req_i.operator)) begin
      case (req_i.vector_mode)
        VEC_MODE8:  cmp_signed = 4'b1111;
        VEC_MODE16: cmp_signed = 4'b1010;
        default:    cmp_signed = 4'b1000;
      endcase
    end
  end

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_byte
    logic [LANE_W-1:0] a_byte;
    logic [LANE_W-1:0] b_byte;

    assign a_byte     = req_i.operand_a[LANE_W*i +: LANE_W];
    assign b_byte     = req_i.operand_b[LANE_W*i +: LANE_W];
    assign eq_byte[i] = (a_byte == b_byte);
    // extend by one bit, sign or zero, then compare as signed
    assign gt_byte[i] = $signed({a_byte[LANE_W-1] & cmp_signed[i], a_byte}) >
                        $signed({b_byte[LANE_W-1] & cmp_signed[i], b_byte});
  end

  ////////////////////
  // element chaining
  ////////////////////

  // upper byte decides unless it is equal
  assign eq_lo16 = eq_byte[1] & eq_byte[0];
  assign eq_hi16 = eq_byte[3] & eq_byte[2];
  assign gt_lo16 = gt_byte[1] | (eq_byte[1] & gt_byte[0]);
  assign gt_hi16 = gt_byte[3] | (eq_byte[3] & gt_byte[2]);

  // word from the two halves
  assign eq_32 = eq_hi16 & eq_lo16;
  assign gt_32 = gt_hi16 | (eq_hi16 & gt_lo16);

  // copy element flags over its byte lanes
  always_comb begin
    case (req_i.vector_mode)
      VEC_MODE8: begin
        flags_o.is_equal   = eq_byte;
        flags_o.is_greater = gt_byte;
      end
      VEC_MODE16: begin
        flags_o.is_equal   = {{2{eq_hi16}}, {2{eq_lo16}}};
        flags_o.is_greater = {{2{gt_hi16}}, {2{gt_lo16}}};
      end
      default: begin
        flags_o.is_equal   = {NUM_LANES{eq_32}};
        flags_o.is_greater = {NUM_LANES{gt_32}};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/alu_op_pkg.sv
// SIMD ALU operation encoding
`default_nettype none

package alu_op_pkg;

  ////////////////////
  // opcodes
  ////////////////////

  // arithmetic and logic
  typedef enum logic [4:0] {
    ADD   = 5'd0,  SUB   = 5'd1,  ABS   = 5'd2,
    AND   = 5'd3,  OR    = 5'd4,  XOR   = 5'd5,
    // per-lane masks
    EQ    = 5'd6,  NE    = 5'd7,
    GTS   = 5'd8,  GES   = 5'd9,  LTS   = 5'd10, LES   = 5'd11,
    GTU   = 5'd12, GEU   = 5'd13, LTU   = 5'd14, LEU   = 5'd15,
    // scalar set-less-than, 0/1 result
    SLTS  = 5'd16, SLTU  = 5'd17, SLETS = 5'd18, SLETU = 5'd19,
    // per-lane select
    MIN   = 5'd20, MINU  = 5'd21, MAX   = 5'd22, MAXU  = 5'd23
  } alu_opcode_e;

  // lane split of the 32-bit word
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  ////////////////////
  // grouping helpers
  ////////////////////

  // top byte of each element compares as two's complement
  function automatic logic op_is_signed(alu_opcode_e op);
    return op inside {GTS, GES, LTS, LES, SLTS, SLETS, MIN, MAX, ABS};
  endfunction

  // adder takes ~b plus one per lane
  function automatic logic op_negates_b(alu_opcode_e op);
    return op == SUB;
  endfunction

endpackage

`default_nettype wire

//--- verilog/alu_result_mux.sv
// SIMD ALU result select
`timescale 1ns/1ps
`default_nettype none

module alu_result_mux
  import alu_op_pkg::*, alu_data_pkg::*;
(
  input  alu_req_t   req_i,
  input  word_t      sum_i,
  input  cmp_flags_t flags_i,
  output alu_res_t   res_o
);

  lane_mask_t cmp_result;
  lane_mask_t sel_a;
  logic       do_min;
  word_t      minmax_b;
  word_t      minmax_result;
  word_t      cmp_mask;
  word_t      result;

  ////////////////////
  // compare outcome
  ////////////////////

  // equality by default, so non-compare ops report top-lane eq
  always_comb begin
    cmp_result = flags_i.is_equal;
    case (req_i.operator)
      NE:                     cmp_result = ~flags_i.is_equal;
      GTS, GTU:               cmp_result = flags_i.is_greater;
      GES, GEU:               cmp_result = flags_i.is_greater | flags_i.is_equal;
      LTS, LTU, SLTS, SLTU:   cmp_result = ~(flags_i.is_greater | flags_i.is_equal);
      LES, LEU, SLETS, SLETU: cmp_result = ~flags_i.is_greater;
      default: ;
    endcase
  end

  ////////////////////
  // min / max / abs
  ////////////////////

  assign do_min = req_i.operator inside {MIN, MINU};

  // a wins when greater for max, when not greater for min
  assign sel_a = flags_i.is_greater ^ {NUM_LANES{do_min}};

  // abs chooses between a and the negated a from the adder
  assign minmax_b = (req_i.operator == ABS) ? sum_i : req_i.operand_b;

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    assign minmax_result[LANE_W*i +: LANE_W] = sel_a[i] ? req_i.operand_a[LANE_W*i +: LANE_W] :
                                                         minmax_b[LANE_W*i +: LANE_W];
    // all-ones or zeros per byte
    assign cmp_mask[LANE_W*i +: LANE_W]      = {LANE_W{cmp_result[i]}};
  end

  ////////////////////
  // final word
  ////////////////////

  always_comb begin
    case (req_i.operator)
      AND:                        result = req_i.operand_a & req_i.operand_b;
      OR:                         result = req_i.operand_a | req_i.operand_b;
      XOR:                        result = req_i.operand_a ^ req_i.operand_b;
      ADD, SUB:                   result = sum_i;
      ABS, MIN, MINU, MAX, MAXU:  result = minmax_result;
      EQ, NE, GTS, GES, LTS, LES,
      GTU, GEU, LTU, LEU:         result = cmp_mask;
      // scalar form uses only the top element
      SLTS, SLTU, SLETS, SLETU:   result = {{(WORD_W-1){1'b0}}, cmp_result[NUM_LANES-1]};
      default:                    result = '0;
    endcase
  end

  assign res_o.result            = result;
  assign res_o.comparison_result = cmp_result[NUM_LANES-1];

endmodule

`default_nettype wire

//--- verilog/alu_stage_reg.sv
// Valid/ready pipeline register
`timescale 1ns/1ps
`default_nettype none

module alu_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,
  // upstream side
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  // downstream side
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     valid_q;
  payload_t data_q;

  // free slot, or the held item leaves on this edge
  assign ready_o = ~valid_q | ready_i;

  // occupancy flag
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // payload only moves on a transfer
  // held otherwise so the output is stable under a stall
  always_ff @(posedge clk) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- verilog/alu_top.sv
// SIMD integer ALU, two-stage pipeline
`timescale 1ns/1ps
`default_nettype none

module alu_top
  import alu_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  // request side
  input  logic     enable_i,
  input  alu_req_t req_i,
  output logic     ready_o,
  // result side
  output logic     result_valid_o,
  output alu_res_t result_o,
  input  logic     ex_ready_i
);

  logic       req_valid;
  logic       res_ready;
  alu_req_t   req_q;
  word_t      sum;
  cmp_flags_t flags;
  alu_res_t   res_d;

  ////////////////////
  // input stage
  ////////////////////

  alu_stage_reg #(
    .payload_t(alu_req_t)
  ) in_stage_i (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .valid_i(enable_i),
    .data_i (req_i),
    .ready_o(ready_o),
    .valid_o(req_valid),
    .data_o (req_q),
    .ready_i(res_ready)
  );

  ////////////////////
  // datapath
  ////////////////////

  // adder and comparator run side by side on the held request
  alu_lane_adder adder_i (
    .req_i(req_q),
    .sum_o(sum)
  );

  alu_lane_compare compare_i (
    .req_i  (req_q),
    .flags_o(flags)
  );

  alu_result_mux mux_i (
    .req_i  (req_q),
    .sum_i  (sum),
    .flags_i(flags),
    .res_o  (res_d)
  );

  ////////////////////
  // output stage
  ////////////////////

  // its ready closes the input stage when results back up
  alu_stage_reg #(
    .payload_t(alu_res_t)
  ) out_stage_i (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .valid_i(req_valid),
    .data_i (res_d),
    .ready_o(res_ready),
    .valid_o(result_valid_o),
    .data_o (result_o),
    .ready_i(ex_ready_i)
  );

endmodule

`default_nettype wire
